//--- common/cpu_pkg.sv
package cpu_pkg;

  typedef logic [31:0] word_t;
  typedef logic [31:0] addr_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [4:0]  shamt_t;

  // Primary opcodes
  localparam logic [5:0] OP_RTYPE = 6'h00;
  localparam logic [5:0] OP_J     = 6'h02;
  localparam logic [5:0] OP_JAL   = 6'h03;
  localparam logic [5:0] OP_BEQ   = 6'h04;
  localparam logic [5:0] OP_BNE   = 6'h05;
  localparam logic [5:0] OP_ADDI  = 6'h08;
  localparam logic [5:0] OP_SLTI  = 6'h0a;
  localparam logic [5:0] OP_SLTIU = 6'h0b;
  localparam logic [5:0] OP_ANDI  = 6'h0c;
  localparam logic [5:0] OP_ORI   = 6'h0d;
  localparam logic [5:0] OP_LW    = 6'h23;
  localparam logic [5:0] OP_SW    = 6'h2b;

  // R-type funct codes
  localparam logic [5:0] FN_SLL  = 6'h00;
  localparam logic [5:0] FN_SRL  = 6'h02;
  localparam logic [5:0] FN_SLLV = 6'h04;
  localparam logic [5:0] FN_SRLV = 6'h06;
  localparam logic [5:0] FN_ADD  = 6'h20;
  localparam logic [5:0] FN_SUB  = 6'h22;
  localparam logic [5:0] FN_AND  = 6'h24;
  localparam logic [5:0] FN_OR   = 6'h25;
  localparam logic [5:0] FN_XOR  = 6'h26;
  localparam logic [5:0] FN_NOR  = 6'h27;
  localparam logic [5:0] FN_SLT  = 6'h2a;
  localparam logic [5:0] FN_SLTU = 6'h2b;

  localparam reg_addr_t REG_LINK = 5'd31;  // jal return address

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_NOR,
    ALU_SLT,
    ALU_SLTU,
    ALU_SLL,
    ALU_SRL,
    ALU_PASS_B  // Carries the jal link value
  } alu_op_t;

endpackage

//--- fetch/instr_mem.sv
`timescale 1ns/100ps

module instr_mem import cpu_pkg::*; #(
  parameter int IMEM_WORDS = 64
) (
  input  logic  clk,
  input  logic  reset,
  input  logic  run,
  input  logic  load_req,
  input  addr_t load_addr,
  input  word_t load_data,
  output logic  load_ack,
  input  addr_t rd_addr,
  output word_t rd_data
);

  localparam int IMEM_AW = $clog2(IMEM_WORDS);

  typedef enum logic {LOAD_IDLE, LOAD_ACK} load_state_t;

  load_state_t load_state;
  word_t       mem [IMEM_WORDS];

  always_ff @(posedge clk) begin
    if (reset) begin
      load_state <= LOAD_IDLE;
    end else begin
      case (load_state)
        LOAD_IDLE: if (load_req) load_state <= LOAD_ACK;
        LOAD_ACK:  if (!load_req) load_state <= LOAD_IDLE;  // Wait for req to drop
        default:   load_state <= LOAD_IDLE;
      endcase
    end
  end

  // One word per handshake, taken on entry to LOAD_ACK
  always_ff @(posedge clk) begin
    if (load_state == LOAD_IDLE && load_req) begin
      mem[load_addr[IMEM_AW-1:0]] <= load_data;
    end
  end

  assign load_ack = (load_state == LOAD_ACK);
  assign rd_data  = mem[rd_addr[IMEM_AW+1:2]];  // Byte address to word index

  a_no_load_while_run: assert property (@(posedge clk) disable iff (reset)
    run |-> !$rose(load_req));

  a_ack_needs_req: assert property (@(posedge clk) disable iff (reset)
    $rose(load_ack) |-> $past(load_req));

endmodule

//--- fetch/fetch_unit.sv
`timescale 1ns/100ps

module fetch_unit import cpu_pkg::*; #(
  parameter int IMEM_WORDS = 64
) (
  input  logic  clk,
  input  logic  reset,
  input  logic  run,
  input  logic  load_req,
  input  addr_t load_addr,
  input  word_t load_data,
  output logic  load_ack,
  input  logic  redirect,
  input  addr_t redirect_pc,
  output logic  fetch_valid,
  output addr_t fetch_pc,
  output word_t fetch_instr
);

  addr_t pc;
  word_t rd_data;

  instr_mem #(
    .IMEM_WORDS(IMEM_WORDS)
  ) u_instr_mem (
    .clk       (clk),
    .reset     (reset),
    .run       (run),
    .load_req  (load_req),
    .load_addr (load_addr),
    .load_data (load_data),
    .load_ack  (load_ack),
    .rd_addr   (pc),
    .rd_data   (rd_data)
  );

  always_ff @(posedge clk) begin
    if (reset) begin
      pc          <= '0;
      fetch_valid <= 1'b0;
    end else begin
      fetch_valid <= run;
      if (run) begin
        pc <= redirect ? redirect_pc : pc + 32'd4;  // Held while stopped
      end
    end
  end

  always_ff @(posedge clk) begin
    if (run) begin
      fetch_pc    <= pc;
      fetch_instr <= rd_data;
    end
  end

endmodule

//--- decode/control_decoder.sv
`timescale 1ns/100ps

module control_decoder import cpu_pkg::*; (
  input  word_t   instr,
  output logic    reg_dst,
  output logic    reg_wr,
  output logic    alu_src,
  output logic    ext_signed,
  output logic    shift_imm,
  output logic    shift_var,
  output logic    mem_wr,
  output logic    mem_to_reg,
  output logic    branch_eq,
  output logic    branch_ne,
  output logic    jump,
  output logic    link,
  output alu_op_t alu_op
);

  logic [5:0] opcode;
  logic [5:0] funct;

  assign opcode = instr[31:26];
  assign funct  = instr[5:0];

  always_comb begin
    reg_dst    = 1'b0;
    reg_wr     = 1'b0;
    alu_src    = 1'b0;
    ext_signed = 1'b0;
    shift_imm  = 1'b0;
    shift_var  = 1'b0;
    mem_wr     = 1'b0;
    mem_to_reg = 1'b0;
    branch_eq  = 1'b0;
    branch_ne  = 1'b0;
    jump       = 1'b0;
    link       = 1'b0;
    alu_op     = ALU_ADD;

    case (opcode)
      OP_RTYPE: begin
        reg_dst = 1'b1;
        reg_wr  = 1'b1;
        case (funct)
          FN_ADD:  alu_op = ALU_ADD;
          FN_SUB:  alu_op = ALU_SUB;
          FN_AND:  alu_op = ALU_AND;
          FN_OR:   alu_op = ALU_OR;
          FN_XOR:  alu_op = ALU_XOR;
          FN_NOR:  alu_op = ALU_NOR;
          FN_SLT:  alu_op = ALU_SLT;
          FN_SLTU: alu_op = ALU_SLTU;
          FN_SLL: begin
            alu_op    = ALU_SLL;
            shift_imm = 1'b1;
          end
          FN_SRL: begin
            alu_op    = ALU_SRL;
            shift_imm = 1'b1;
          end
          FN_SLLV: begin
            alu_op    = ALU_SLL;
            shift_var = 1'b1;
          end
          FN_SRLV: begin
            alu_op    = ALU_SRL;
            shift_var = 1'b1;
          end
          default: reg_wr = 1'b0;  // Unknown funct retires as a no-op
        endcase
      end
      OP_ADDI, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI: begin
        reg_wr     = 1'b1;
        alu_src    = 1'b1;
        ext_signed = (opcode != OP_ANDI) && (opcode != OP_ORI);
        case (opcode)
          OP_SLTI:  alu_op = ALU_SLT;
          OP_SLTIU: alu_op = ALU_SLTU;  // Sign-extended, compared unsigned
          OP_ANDI:  alu_op = ALU_AND;
          OP_ORI:   alu_op = ALU_OR;
          default:  alu_op = ALU_ADD;
        endcase
      end
      OP_LW: begin
        reg_wr     = 1'b1;
        alu_src    = 1'b1;
        ext_signed = 1'b1;
        mem_to_reg = 1'b1;
      end
      OP_SW: begin
        alu_src    = 1'b1;
        ext_signed = 1'b1;
        mem_wr     = 1'b1;
      end
      OP_BEQ: begin
        branch_eq = 1'b1;
        alu_op    = ALU_SUB;
      end
      OP_BNE: begin
        branch_ne = 1'b1;
        alu_op    = ALU_SUB;
      end
      OP_J: jump = 1'b1;
      OP_JAL: begin
        jump   = 1'b1;
        link   = 1'b1;
        reg_wr = 1'b1;
        alu_op = ALU_PASS_B;
      end
      default: ;
    endcase
  end

endmodule

//--- execute/reg_file.sv
`timescale 1ns/100ps

module reg_file import cpu_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  reg_addr_t rs_addr,
  input  reg_addr_t rt_addr,
  output word_t     rs_data,
  output word_t     rt_data,
  input  logic      wr_en,
  input  reg_addr_t wr_addr,
  input  word_t     wr_data
);

  word_t regs [32];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en && wr_addr != '0) begin
      regs[wr_addr] <= wr_data;
    end
  end

  assign rs_data = regs[rs_addr];
  assign rt_data = regs[rt_addr];

  // Holds across every write that reached the file
  a_r0_zero: assert property (@(posedge clk) disable iff (reset)
    (rs_addr != '0 || rs_data == '0) && (rt_addr != '0 || rt_data == '0));

endmodule

//--- execute/alu.sv
`timescale 1ns/100ps

module alu import cpu_pkg::*; (
  input  alu_op_t op,
  input  word_t   a,
  input  word_t   b,
  output word_t   result,
  output logic    zero
);

  shamt_t sh;

  assign sh = a[4:0];

  always_comb begin
    case (op)
      ALU_ADD:    result = a + b;
      ALU_SUB:    result = a - b;
      ALU_AND:    result = a & b;
      ALU_OR:     result = a | b;
      ALU_XOR:    result = a ^ b;
      ALU_NOR:    result = ~(a | b);
      ALU_SLT:    result = {31'd0, $signed(a) < $signed(b)};
      ALU_SLTU:   result = {31'd0, a < b};
      ALU_SLL:    result = b << sh;  // Shift amount rides on a
      ALU_SRL:    result = b >> sh;
      ALU_PASS_B: result = b;
      default:    result = '0;
    endcase
  end

  assign zero = (result == '0);  // beq and bne after subtract

endmodule

//--- execute/execute_stage.sv
`timescale 1ns/100ps

module execute_stage import cpu_pkg::*; #(
  parameter int DMEM_WORDS = 64
) (
  input  logic    clk,
  input  logic    reset,
  input  logic    fetch_valid,
  input  addr_t   fetch_pc,
  input  word_t   fetch_instr,
  input  logic    reg_dst,
  input  logic    reg_wr,
  input  logic    alu_src,
  input  logic    ext_signed,
  input  logic    shift_imm,
  input  logic    shift_var,
  input  logic    mem_wr,
  input  logic    mem_to_reg,
  input  logic    branch_eq,
  input  logic    branch_ne,
  input  logic    jump,
  input  logic    link,
  input  alu_op_t alu_op,
  output logic    redirect,
  output addr_t   redirect_pc,
  output logic    retire_valid,
  output addr_t   retire_pc,
  output word_t   retire_instr,
  output word_t   alu_out
);

  localparam int DMEM_AW = $clog2(DMEM_WORDS);

  reg_addr_t          rs;
  reg_addr_t          rt;
  reg_addr_t          rd;
  reg_addr_t          wr_addr;
  shamt_t             shamt;
  word_t              rs_data;
  word_t              rt_data;
  word_t              imm_ext;
  word_t              op_a;
  word_t              op_b;
  word_t              alu_result;
  word_t              wr_data;
  addr_t              pc_plus4;
  addr_t              branch_target;
  addr_t              jump_target;
  logic               zero;
  logic               take_branch;
  logic [DMEM_AW-1:0] dmem_idx;
  word_t              dmem [DMEM_WORDS];

  assign rs    = fetch_instr[25:21];
  assign rt    = fetch_instr[20:16];
  assign rd    = fetch_instr[15:11];
  assign shamt = fetch_instr[10:6];

  assign imm_ext = {{16{ext_signed & fetch_instr[15]}}, fetch_instr[15:0]};
  assign pc_plus4 = fetch_pc + 32'd4;

  assign op_a = shift_imm ? {27'd0, shamt} :
                shift_var ? {27'd0, rs_data[4:0]} : rs_data;
  assign op_b = link    ? pc_plus4 + 32'd4 :  // Link value is pc+8
                alu_src ? imm_ext : rt_data;

  reg_file u_reg_file (
    .clk     (clk),
    .reset   (reset),
    .rs_addr (rs),
    .rt_addr (rt),
    .rs_data (rs_data),
    .rt_data (rt_data),
    .wr_en   (fetch_valid & reg_wr),
    .wr_addr (wr_addr),
    .wr_data (wr_data)
  );

  alu u_alu (
    .op     (alu_op),
    .a      (op_a),
    .b      (op_b),
    .result (alu_result),
    .zero   (zero)
  );

  assign dmem_idx = alu_result[DMEM_AW+1:2];
  assign wr_addr  = link ? REG_LINK : (reg_dst ? rd : rt);
  assign wr_data  = mem_to_reg ? dmem[dmem_idx] : alu_result;

  always_ff @(posedge clk) begin
    if (fetch_valid && mem_wr) begin
      dmem[dmem_idx] <= rt_data;
    end
  end

  assign branch_target = pc_plus4 + {{14{fetch_instr[15]}}, fetch_instr[15:0], 2'b00};
  assign jump_target   = {pc_plus4[31:28], fetch_instr[25:0], 2'b00};
  assign take_branch   = (branch_eq & zero) | (branch_ne & ~zero);
  assign redirect      = fetch_valid & (jump | take_branch);  // Stale word on a bubble
  assign redirect_pc   = jump ? jump_target : branch_target;

  always_ff @(posedge clk) begin
    if (reset) begin
      retire_valid <= 1'b0;
    end else begin
      retire_valid <= fetch_valid;
    end
  end

  always_ff @(posedge clk) begin
    retire_pc    <= fetch_pc;
    retire_instr <= fetch_instr;
    alu_out      <= alu_result;
  end

endmodule

//--- hw/cpu_top.sv
`timescale 1ns/100ps

module cpu_top import cpu_pkg::*; #(
  parameter int IMEM_WORDS = 64,
  parameter int DMEM_WORDS = 64
) (
  input  logic  clk,
  input  logic  reset,
  input  logic  run,
  input  logic  load_req,
  input  addr_t load_addr,  // Word index
  input  word_t load_data,
  output logic  load_ack,
  output logic  retire_valid,
  output addr_t retire_pc,
  output word_t retire_instr,
  output word_t alu_out
);

  logic    fetch_valid;
  addr_t   fetch_pc;
  word_t   fetch_instr;
  logic    redirect;
  addr_t   redirect_pc;
  logic    reg_dst;
  logic    reg_wr;
  logic    alu_src;
  logic    ext_signed;
  logic    shift_imm;
  logic    shift_var;
  logic    mem_wr;
  logic    mem_to_reg;
  logic    branch_eq;
  logic    branch_ne;
  logic    jump;
  logic    link;
  alu_op_t alu_op;

  fetch_unit #(
    .IMEM_WORDS(IMEM_WORDS)
  ) u_fetch_unit (
    .clk         (clk),
    .reset       (reset),
    .run         (run),
    .load_req    (load_req),
    .load_addr   (load_addr),
    .load_data   (load_data),
    .load_ack    (load_ack),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .fetch_valid (fetch_valid),
    .fetch_pc    (fetch_pc),
    .fetch_instr (fetch_instr)
  );

  control_decoder u_control_decoder (
    .instr      (fetch_instr),
    .reg_dst    (reg_dst),
    .reg_wr     (reg_wr),
    .alu_src    (alu_src),
    .ext_signed (ext_signed),
    .shift_imm  (shift_imm),
    .shift_var  (shift_var),
    .mem_wr     (mem_wr),
    .mem_to_reg (mem_to_reg),
    .branch_eq  (branch_eq),
    .branch_ne  (branch_ne),
    .jump       (jump),
    .link       (link),
    .alu_op     (alu_op)
  );

  execute_stage #(
    .DMEM_WORDS(DMEM_WORDS)
  ) u_execute_stage (
    .clk          (clk),
    .reset        (reset),
    .fetch_valid  (fetch_valid),
    .fetch_pc     (fetch_pc),
    .fetch_instr  (fetch_instr),
    .reg_dst      (reg_dst),
    .reg_wr       (reg_wr),
    .alu_src      (alu_src),
    .ext_signed   (ext_signed),
    .shift_imm    (shift_imm),
    .shift_var    (shift_var),
    .mem_wr       (mem_wr),
    .mem_to_reg   (mem_to_reg),
    .branch_eq    (branch_eq),
    .branch_ne    (branch_ne),
    .jump         (jump),
    .link         (link),
    .alu_op       (alu_op),
    .redirect     (redirect),
    .redirect_pc  (redirect_pc),
    .retire_valid (retire_valid),
    .retire_pc    (retire_pc),
    .retire_instr (retire_instr),
    .alu_out      (alu_out)
  );

endmodule

//--- dv/tb_top.sv
`timescale 1ns/100ps

module tb_top;

  logic        clk;
  logic        reset;
  logic        run;
  logic        load_req;
  logic [31:0] load_addr;
  logic [31:0] load_data;
  logic        load_ack;
  logic        retire_valid;
  logic [31:0] retire_pc;
  logic [31:0] retire_instr;
  logic [31:0] alu_out;

  logic [31:0] p_idx_q [$];
  logic [31:0] p_word_q [$];
  logic [31:0] e_pc_q [$];
  logic [31:0] e_alu_q [$];
  logic [31:0] prog [int];  // Loaded words by word index
  int          cycle_count;
  int          cycle_limit;

  cpu_top DUT (
    .clk          (clk),
    .reset        (reset),
    .run          (run),
    .load_req     (load_req),
    .load_addr    (load_addr),
    .load_data    (load_data),
    .load_ack     (load_ack),
    .retire_valid (retire_valid),
    .retire_pc    (retire_pc),
    .retire_instr (retire_instr),
    .alu_out      (alu_out)
  );

  always #10 clk = ~clk;

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("RESULT: FAIL");
    $fatal(1, "Simulation stopped on first error");
  endtask

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > cycle_limit) begin
      fail_run($sformatf("Timeout: the run did not finish within %0d cycles", cycle_limit));
    end
  end

  // Outputs settle by now, inputs change here
  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic read_testdata();
    int          fd;
    int          ch;
    int          code;
    logic [31:0] a;
    logic [31:0] b;
    fd = $fopen("dv/cpu_testdata.hex", "r");
    if (fd == 0) begin
      fail_run("Could not open the test data file dv/cpu_testdata.hex");
    end
    ch = $fgetc(fd);
    while (ch != -1) begin
      if (ch == int'("P") || ch == int'("E")) begin
        code = $fscanf(fd, "%h %h", a, b);
        if (code != 2) begin
          fail_run("A line of the test data file has too few values");
        end
        if (ch == int'("P")) begin
          p_idx_q.push_back(a);
          p_word_q.push_back(b);
          prog[int'(a)] = b;
        end else begin
          e_pc_q.push_back(a);
          e_alu_q.push_back(b);
        end
      end else if (ch == int'("#")) begin
        while (ch != 10 && ch != -1) begin
          ch = $fgetc(fd);  // Skip comment line
        end
      end else if (ch != 10 && ch != 13 && ch != 32 && ch != 9) begin
        fail_run("The test data file holds a line with an unknown tag");
      end
      ch = $fgetc(fd);
    end
    $fclose(fd);
  endtask

  task automatic load_word(input logic [31:0] idx, input logic [31:0] word);
    int waited;
    int gap;
    assert (!load_ack) else
      fail_run($sformatf("ERROR at %0t: load_ack high before request", $time));
    load_req  = 1'b1;
    load_addr = idx;
    load_data = word;
    waited    = 0;
    do begin
      next_cycle();
      waited++;
    end while (!load_ack);
    assert (waited == 1) else
      fail_run($sformatf("ERROR at %0t: load_ack rose after %0d cycles, expected 1",
                         $time, waited));
    load_req = 1'b0;
    waited   = 0;
    do begin
      next_cycle();
      waited++;
    end while (load_ack);
    assert (waited == 1) else
      fail_run($sformatf("ERROR at %0t: load_ack fell after %0d cycles, expected 1",
                         $time, waited));
    gap = int'($urandom % 4);
    repeat (gap) next_cycle();
  endtask

  task automatic check_retire(input int n);
    logic [31:0] exp_instr;
    assert (retire_pc == e_pc_q[n]) else
      fail_run($sformatf("ERROR at %0t: retire %0d pc expected %08h, got %08h",
                         $time, n, e_pc_q[n], retire_pc));
    assert (alu_out == e_alu_q[n]) else
      fail_run($sformatf("ERROR at %0t: retire %0d alu_out expected %08h, got %08h",
                         $time, n, e_alu_q[n], alu_out));
    assert (prog.exists(int'(retire_pc >> 2))) else
      fail_run($sformatf("ERROR at %0t: retired pc %08h was never loaded", $time, retire_pc));
    exp_instr = prog[int'(retire_pc >> 2)];
    assert (retire_instr == exp_instr) else
      fail_run($sformatf("ERROR at %0t: retire %0d instr expected %08h, got %08h",
                         $time, n, exp_instr, retire_instr));
  endtask

  initial begin
    int waited;
    int checked;
    clk         = 1'b0;
    reset       = 1'b1;
    run         = 1'b0;
    load_req    = 1'b0;
    load_addr   = '0;
    load_data   = '0;
    cycle_count = 0;
    checked     = 0;
    void'($urandom(32'hc700ffca));
    read_testdata();
    cycle_limit = 20 + 10 * p_idx_q.size() + 4 * e_pc_q.size() + 50;

    repeat (10) begin
      next_cycle();
      assert (!load_ack && !retire_valid) else
        fail_run($sformatf("ERROR at %0t: load_ack or retire_valid high in reset", $time));
    end
    reset = 1'b0;
    next_cycle();
    assert (!load_ack && !retire_valid) else
      fail_run($sformatf("ERROR at %0t: load_ack or retire_valid high after reset", $time));

    foreach (p_idx_q[i]) begin
      load_word(p_idx_q[i], p_word_q[i]);
    end

    run    = 1'b1;
    waited = 0;
    do begin
      next_cycle();
      waited++;
    end while (!retire_valid);
    assert (waited == 2) else
      fail_run($sformatf("ERROR at %0t: first retire after %0d cycles, expected 2",
                         $time, waited));

    foreach (e_pc_q[n]) begin
      if (n > 0) begin
        next_cycle();
        assert (retire_valid) else
          fail_run($sformatf("ERROR at %0t: gap in retire stream before retire %0d",
                             $time, n));
      end
      check_retire(n);
      checked++;
    end

    run = 1'b0;
    repeat (3) next_cycle();
    assert (!retire_valid) else
      fail_run($sformatf("ERROR at %0t: retire_valid still high after run fell", $time));

    if (checked > 0 && checked == e_pc_q.size()) begin
      $display("RESULT: PASS");
      $finish;
    end else begin
      $display("RESULT: FAIL");
      $fatal(1, "No expected retire entries were checked");
    end
  end

endmodule

//--- dv/cpu_testdata.hex
# P <word index> <instruction word>, all values hex
# E <expected retire_pc> <expected alu_out>, in retire order
P 00000000 2001FFFB
P 00000001 34028001
P 00000002 0022182A
P 00000003 0022202B
P 00000004 2825FFFC
P 00000005 2C46FFFF
P 00000006 3027FF0F
P 00000007 00414022
P 00000008 00E24827
P 00000009 01285026
P 0000000A 00025900
P 0000000B 00016702
P 0000000C 01826804
P 0000000D 00A17006
P 0000000E AC0B0008
P 0000000F 8C0F0008
P 00000010 01E88020
P 00000011 10A60002
P 00000012 20110001
P 00000013 20110063
P 00000014 14650005
P 00000015 02119025
P 00000016 16400002
P 00000017 024D9824
P 00000018 20130055
P 00000019 0C000020
P 0000001A 20140007
P 00000020 03F4A820
P 00000021 08000021
P 00000022 00000000
E 00000000 FFFFFFFB
E 00000004 00008001
E 00000008 00000001
E 0000000C 00000000
E 00000010 00000001
E 00000014 00000001
E 00000018 0000FF0B
E 0000001C 00008006
E 00000020 FFFF00F4
E 00000024 FFFF80F2
E 00000028 00080010
E 0000002C 0000000F
E 00000030 40008000
E 00000034 7FFFFFFD
E 00000038 00000008
E 0000003C 00000008
E 00000040 00088016
E 00000044 00000000
E 00000048 00000001
E 00000050 00000000
E 00000054 00088017
E 00000058 00088017
E 0000005C 00008000
E 00000064 0000006C
E 00000068 00000007
E 00000080 00000073
E 00000084 00000000
E 00000088 00000000
E 00000084 00000000

//--- tb.f
common/cpu_pkg.sv
fetch/instr_mem.sv
fetch/fetch_unit.sv
decode/control_decoder.sv
execute/reg_file.sv
execute/alu.sv
execute/execute_stage.sv
hw/cpu_top.sv
dv/tb_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Compile and run the testbench with Verilator, then check the log.

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --assert -j 0 --top-module tb_top -f tb.f -o tb_sim > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
  cat "$BUILD_LOG"
  echo "Verilator compile failed"
  exit 1
fi

./obj_dir/tb_sim > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"

if grep -q "RESULT: FAIL" "$SIM_LOG"; then
  exit 1
fi
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi
exit 0
